//--- vlog.f
+incdir+.
csa_pkg.sv
csa_reg_a.sv
csa_reg_b.sv
csa_combiner.sv
csa_step_ctrl.sv
csa_calc_logic.sv
csa_calc_logic_tb.sv

//--- csa_calc_logic_tb.sv
`timescale 1ns/1ps

module csa_calc_logic_tb;
	import csa_pkg::*;

	localparam logic [7:0] ENGINE_ID  = 8'd8;
	localparam int         ROWS       = 16;
	localparam int         FIXED_ROWS = 6;
	localparam int         IW         = $bits(csa_in_t);
	localparam int         OW         = $bits(csa_out_t);

	logic       clk;
	logic       rst_n;
	logic       request;
	csa_times_t times;
	csa_in_t    seed_in;
	logic       release_strobe;
	logic       ready;
	logic       inuse;
	csa_out_t   result;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus table
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	string      name_tab[ROWS];
	csa_in_t    seed_tab[ROWS];
	csa_times_t times_tab[ROWS];
	csa_out_t   expect_tab[ROWS];

	logic [31:0] rng_state;
	int          cycle_count;
	int          cycle_limit;

	csa_calc_logic #(
		.ID (ENGINE_ID)
	) uut (
		.clk                    (clk),
		.rst_n                  (rst_n),
		.csa_calc_logic_request (request),
		.csa_calc_logic_times   (times),
		.csa_calc_logic_in      (seed_in),
		.csa_calc_logic_reset   (release_strobe),
		.csa_calc_logic_ready   (ready),
		.csa_calc_logic_inuse   (inuse),
		.csa_calc_logic_out     (result)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Shift left with the taps applied when the top bit falls out
	function automatic csa_in_t advance_a(input csa_in_t a);
		csa_in_t shifted;
		shifted = a << 1;
		if (a[IW-1]) begin
			shifted = shifted ^ CSA_A_POLY;
		end
		return shifted;
	endfunction

	function automatic csa_in_t advance_b(input csa_in_t b);
		csa_in_t    rot;
		logic [7:0] mix;
		rot      = (b << 3) | (b >> (IW - 3));
		mix      = b[IW-1 -: 8] & b[15:8]; // Old top byte with old byte 1
		rot[7:0] = rot[7:0] ^ mix;
		return rot;
	endfunction

	function automatic csa_out_t expected_result(input csa_in_t seed, input csa_times_t n);
		csa_in_t  a;
		csa_in_t  b;
		csa_out_t acc;
		csa_out_t a_term;
		csa_out_t b_term;
		a   = seed;
		b   = seed ^ CSA_B_MASK ^ csa_in_t'(ENGINE_ID);
		acc = '0;
		for (int i = 0; i < n; i++) begin
			a_term = csa_out_t'(a);
			b_term = csa_out_t'(b) << (OW - IW);
			acc    = (acc << 5) | (acc >> (OW - 5));
			acc    = acc ^ a_term ^ b_term; // Uses A and B before they advance
			a      = advance_a(a);
			b      = advance_b(b);
		end
		return acc;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Error reporting
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic value_mismatch(input string test_name, input string what,
			input logic [OW-1:0] expected, input logic [OW-1:0] actual);
		$display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic flag_failure(input string test_name, input string text);
		$display("Failure in %s: %s", test_name, text);
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
			$display("Regression failed");
			$fatal(1, "stopped by the cycle limit");
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Table setup
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic build_table();
		logic [31:0] hi;
		logic [31:0] lo;
		name_tab[0] = "zero_seed";
		seed_tab[0] = '0;
		times_tab[0] = 5;
		name_tab[1] = "ones_seed";
		seed_tab[1] = '1;
		times_tab[1] = 9;
		name_tab[2] = "count_0";
		seed_tab[2] = 40'h12_3456_789A;
		times_tab[2] = 0;
		name_tab[3] = "count_1";
		seed_tab[3] = 40'hFE_DCBA_9876;
		times_tab[3] = 1;
		name_tab[4] = "count_2";
		seed_tab[4] = 40'h0F_1E2D_3C4B;
		times_tab[4] = 2;
		name_tab[5] = "count_63";
		seed_tab[5] = 40'h5A_5A5A_A5A5;
		times_tab[5] = 63;
		for (int i = FIXED_ROWS; i < ROWS; i++) begin
			hi           = next_random();
			lo           = next_random();
			name_tab[i]  = $sformatf("random_%0d", i - FIXED_ROWS);
			seed_tab[i]  = {hi[7:0], lo};
			times_tab[i] = next_random() % 64;
		end
		cycle_limit = 200;
		for (int i = 0; i < ROWS; i++) begin
			expect_tab[i] = expected_result(seed_tab[i], times_tab[i]);
			cycle_limit   = cycle_limit + int'(times_tab[i]) + 8;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Job tasks entered and left on a falling edge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check_idle(input string test_name);
		assert (ready === 1'b0) else flag_failure(test_name, "ready is high while idle");
		assert (inuse === 1'b0) else flag_failure(test_name, "inuse is high while idle");
		assert (result === '0) else value_mismatch(test_name, "idle result", '0, result);
	endtask

	// Optional intruding request lands while the job is running
	task automatic run_job(input string test_name, input csa_in_t seed, input csa_times_t n,
			input csa_out_t expected, input logic intrude);
		int edges;
		request = 1'b1;
		times   = n;
		seed_in = seed;
		@(posedge clk); // Edge 0 samples the request
		@(negedge clk);
		request = 1'b0;
		assert (inuse === 1'b1) else
			flag_failure(test_name, "inuse did not rise one cycle after the request");
		if (intrude) begin
			request = 1'b1;
			times   = n + 3;
			seed_in = ~seed;
		end
		edges = 0;
		while (ready !== 1'b1 && edges <= int'(n) + 1) begin
			@(posedge clk);
			edges = edges + 1;
			@(negedge clk);
			request = 1'b0;
		end
		assert (edges == int'(n) + 1) else
			value_mismatch(test_name, "edges to ready", OW'(n + 1), OW'(edges));
		assert (result === expected) else
			value_mismatch(test_name, "result", expected, result);
		repeat (2) @(negedge clk);
		assert (ready === 1'b1) else flag_failure(test_name, "ready dropped before release");
		assert (result === expected) else
			value_mismatch(test_name, "held result", expected, result);
	endtask

	task automatic release_job(input string test_name);
		release_strobe = 1'b1;
		@(posedge clk);
		@(negedge clk);
		release_strobe = 1'b0;
		check_idle(test_name);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		rst_n          = 1'b0;
		request        = 1'b0;
		times          = '0;
		seed_in        = '0;
		release_strobe = 1'b0;
		rng_state      = 32'h5c4f;
		build_table();

		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_idle("after_reset");

		for (int i = 0; i < ROWS; i++) begin
			run_job(name_tab[i], seed_tab[i], times_tab[i], expect_tab[i], 1'b0);
			release_job(name_tab[i]);
		end

		// Busy engine must ignore a second request
		run_job("overlap", seed_tab[0], times_tab[0], expect_tab[0], 1'b1);
		release_job("overlap");

		$display("Regression passed");
		$finish;
	end

endmodule

//--- csa_calc_logic.sv
`timescale 1ns/1ps

module csa_calc_logic #(
	parameter logic [7:0] ID = 8'd8
) (
	input  logic                clk,
	input  logic                rst_n,

	input  logic                csa_calc_logic_request,
	input  csa_pkg::csa_times_t csa_calc_logic_times,
	input  csa_pkg::csa_in_t    csa_calc_logic_in,
	input  logic                csa_calc_logic_reset,

	output logic                csa_calc_logic_ready,
	output logic                csa_calc_logic_inuse,
	output csa_pkg::csa_out_t   csa_calc_logic_out
);
	import csa_pkg::*;

	logic    load;
	logic    step;
	logic    clear;
	csa_in_t a_state;
	csa_in_t b_state;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	csa_step_ctrl u_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.request        (csa_calc_logic_request),
		.times          (csa_calc_logic_times),
		.release_strobe (csa_calc_logic_reset),
		.load           (load),
		.step           (step),
		.clear          (clear),
		.ready          (csa_calc_logic_ready),
		.inuse          (csa_calc_logic_inuse)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Keystream datapath
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	csa_reg_a u_reg_a (
		.clk   (clk),
		.rst_n (rst_n),
		.load  (load),
		.step  (step),
		.seed  (csa_calc_logic_in),
		.state (a_state)
	);

	csa_reg_b #(
		.ID (ID)
	) u_reg_b (
		.clk   (clk),
		.rst_n (rst_n),
		.load  (load),
		.step  (step),
		.seed  (csa_calc_logic_in),
		.state (b_state)
	);

	csa_combiner u_combiner (
		.clk     (clk),
		.rst_n   (rst_n),
		.load    (load),
		.clear   (clear),
		.step    (step),
		.a_state (a_state),
		.b_state (b_state),
		.result  (csa_calc_logic_out)
	);

endmodule

//--- csa_step_ctrl.sv
`timescale 1ns/1ps

module csa_step_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                request,
	input  csa_pkg::csa_times_t times,
	input  logic                release_strobe,
	output logic                load,
	output logic                step,
	output logic                clear,
	output logic                ready,
	output logic                inuse
);
	import csa_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_STEP,
		ST_DONE
	} ctrl_state_t;

	ctrl_state_t cur_state;
	csa_times_t  remain; // Steps still to run

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Strobes and status
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Load on the same edge that takes the request
	assign load  = (cur_state == ST_IDLE) && request && !release_strobe;
	assign step  = (cur_state == ST_STEP) && (remain != '0) && !release_strobe;
	assign clear = release_strobe;
	assign ready = (cur_state == ST_DONE);
	assign inuse = (cur_state != ST_IDLE);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sequencer
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cur_state <= ST_IDLE;
			remain    <= '0;
		end else if (release_strobe) begin
			cur_state <= ST_IDLE; // Release wins in any state
			remain    <= '0;
		end else begin
			case (cur_state)
				ST_IDLE: begin
					if (request) begin
						cur_state <= ST_STEP;
						remain    <= times;
					end
				end
				ST_STEP: begin
					if (remain != '0) begin
						remain <= remain - 1'b1;
					end else begin
						cur_state <= ST_DONE; // One edge after the last step
					end
				end
				ST_DONE: begin
					cur_state <= ST_DONE; // Hold until released
				end
				default: begin
					cur_state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

//--- csa_combiner.sv
`timescale 1ns/1ps

module csa_combiner (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              load,
	input  logic              clear,
	input  logic              step,
	input  csa_pkg::csa_in_t  a_state,
	input  csa_pkg::csa_in_t  b_state,
	output csa_pkg::csa_out_t result
);
	import csa_pkg::*;

	localparam int OW  = $bits(csa_out_t);
	localparam int IW  = $bits(csa_in_t);
	localparam int PAD = OW - IW;

	csa_out_t rotated;
	csa_out_t a_term;
	csa_out_t b_term;
	csa_out_t folded;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Fold
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign rotated = {result[OW-6:0], result[OW-1:OW-5]}; // Rotate left by 5
	assign a_term  = {{PAD{1'b0}}, a_state};               // A in the low bits
	assign b_term  = {b_state, {PAD{1'b0}}};               // B in the high bits
	assign folded  = rotated ^ a_term ^ b_term;

	// A and B are sampled before they advance on the same edge
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result <= '0;
		end else if (clear || load) begin
			result <= '0;
		end else if (step) begin
			result <= folded;
		end
	end

endmodule

//--- csa_reg_b.sv
`timescale 1ns/1ps

module csa_reg_b #(
	parameter logic [7:0] ID = 8'd8
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             load,
	input  logic             step,
	input  csa_pkg::csa_in_t seed,
	output csa_pkg::csa_in_t state
);
	import csa_pkg::*;

	localparam int W = $bits(csa_in_t);

	csa_in_t    load_value;
	csa_in_t    rotated;
	logic [7:0] mix;
	csa_in_t    next_state;

	// Whitened seed with the engine identity in the low byte
	assign load_value = seed ^ CSA_B_MASK ^ {{(W-8){1'b0}}, ID};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Nonlinear step
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign rotated    = {state[W-4:0], state[W-1:W-3]}; // Rotate left by 3
	assign mix        = state[W-1:W-8] & state[15:8];   // Old top byte AND old byte 1
	assign next_state = {rotated[W-1:8], rotated[7:0] ^ mix};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= '0;
		end else if (load) begin
			state <= load_value;
		end else if (step) begin
			state <= next_state;
		end
	end

endmodule

//--- csa_reg_a.sv
`timescale 1ns/1ps

module csa_reg_a (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             load,
	input  logic             step,
	input  csa_pkg::csa_in_t seed,
	output csa_pkg::csa_in_t state
);
	import csa_pkg::*;

	localparam int W = $bits(csa_in_t);

	csa_in_t next_state;

	// Galois form with one shift per step
	always_comb begin
		next_state = {state[W-2:0], 1'b0};
		if (state[W-1]) begin
			next_state = next_state ^ CSA_A_POLY; // Bit fell off the top
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= '0;
		end else if (load) begin
			state <= seed;
		end else if (step) begin
			state <= next_state;
		end
	end

endmodule

//--- csa_pkg.sv
`include "csa_config.svh"

package csa_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Data types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [`CSA_DATA_WIDTH-1:0] csa_times_t; // Steps to run
	typedef logic [`CSA_IN_WIDTH-1:0]   csa_in_t;    // Seed, A and B state
	typedef logic [`CSA_OUT_WIDTH-1:0]  csa_out_t;   // Accumulator

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Mixing constants
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Feedback taps of register A with the top bit at the shifted-out position
	localparam csa_in_t CSA_A_POLY = 40'h80_0000_0053;

	// Whitening for the B seed
	localparam csa_in_t CSA_B_MASK = 40'hA5_C3_96_3C_5A;

endpackage

//--- csa_config.svh
`ifndef CSA_CONFIG_SVH
`define CSA_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Engine widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Step count as one bus word
`define CSA_DATA_WIDTH 32

// Five-byte seed and register state
`define CSA_IN_WIDTH 40

// Six-byte accumulated keystream result
`define CSA_OUT_WIDTH 48

`endif
